/* src.f */
hdl/noc_shim_pkg.sv
hdl/word_fifo.sv
hdl/flit_serializer.sv
hdl/flit_deserializer.sv
hdl/noc_endpoint_shim.sv
tests/clk_gen.sv
tests/noc_shim_properties.sv
tests/tb_noc_shim.sv

/* run.sh */
#!/bin/sh
# Compile and run the NoC endpoint shim testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_noc_shim -f src.f -o tb_noc_shim_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_noc_shim_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1

/* tests/tb_noc_shim.sv */
`timescale 1ns/100ps

module tb_noc_shim;

    logic                     clk_noc;
    logic                     rst_n_noc_sync;
    logic                     tx_valid;
    logic                     tx_ready;
    noc_shim_pkg::axis_beat_t tx_beat;
    logic                     rx_valid;
    logic                     rx_ready;
    noc_shim_pkg::axis_beat_t rx_beat;
    noc_shim_pkg::flit_t      flit_out;
    logic                     send_out;
    logic                     credit_in;
    noc_shim_pkg::flit_t      flit_in;
    logic                     send_in;
    logic                     credit_out;

    // Hold-mode credits and loopback select
    logic                     credit_drv;
    logic                     loopback;

    logic [31:0]              rng_state;
    int                       cycle_count;
    int                       error_count;
    int                       test_count;
    noc_shim_pkg::flit_t      flits_seen[$];

    clk_gen clock (.clk(clk_noc));

    noc_endpoint_shim uut (
        .clk_noc        (clk_noc),
        .rst_n_noc_sync (rst_n_noc_sync),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_beat        (tx_beat),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_beat        (rx_beat),
        .flit_out       (flit_out),
        .send_out       (send_out),
        .credit_in      (credit_in),
        .flit_in        (flit_in),
        .send_in        (send_in),
        .credit_out     (credit_out)
    );

    assign flit_in   = loopback ? flit_out : '0;
    assign send_in   = loopback & send_out;
    assign credit_in = loopback ? credit_out : credit_drv;

    // Whole run needs well under 500 cycles, so 4000 leaves a wide margin
    always @(posedge clk_noc) begin
        cycle_count++;
        if (cycle_count >= 4000) begin
            $display("Timeout: the run did not finish within 4000 cycles");
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [67:0] expected, input logic [67:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: %s expected %h, actual %h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_test(input string test, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", test);
        end else begin
            $display("%s: failed with %0d errors", test, error_count - errors_before);
        end
    endtask

    task automatic send_beat(input noc_shim_pkg::axis_beat_t beat);
        logic done;
        done     = 1'b0;
        tx_beat  = beat;
        tx_valid = 1'b1;
        while (!done) begin
            done = tx_ready;
            @(negedge clk_noc);
        end
        tx_valid = 1'b0;
    endtask

    task automatic recv_beat(input logic random_ready, output noc_shim_pkg::axis_beat_t beat);
        logic        got;
        logic [31:0] rnd;
        got = 1'b0;
        while (!got) begin
            rnd      = next_random();
            rx_ready = random_ready ? rnd[0] : 1'b1;
            if (rx_valid && rx_ready) begin
                beat = rx_beat;
                got  = 1'b1;
            end
            @(negedge clk_noc);
        end
        rx_ready = 1'b0;
    endtask

    task automatic watch_sends(input int cycles);
        repeat (cycles) begin
            @(negedge clk_noc);
            if (send_out) begin
                flits_seen.push_back(flit_out);
            end
        end
    endtask

    task automatic drive_credits(input int count);
        repeat (count) begin
            credit_drv = 1'b1;
            @(negedge clk_noc);
        end
        credit_drv = 1'b0;
    endtask

    task automatic wait_idle();
        while (credit_out || send_out || rx_valid) begin
            @(negedge clk_noc);
        end
    endtask

    task automatic test_reset_idle();
        int errors_before;
        errors_before  = error_count;
        rst_n_noc_sync = 1'b0;
        for (int i = 0; i < 13; i++) begin
            @(negedge clk_noc);
            if (i == 9) begin
                rst_n_noc_sync = 1'b1;
            end
            check_value("reset_idle", "send_out", 1'b0, send_out);
            check_value("reset_idle", "credit_out", 1'b0, credit_out);
            check_value("reset_idle", "rx_valid", 1'b0, rx_valid);
            check_value("reset_idle", "tx_ready", 1'b1, tx_ready);
        end
        finish_test("reset_idle", errors_before);
    endtask

    task automatic test_single_word();
        int                       errors_before;
        noc_shim_pkg::axis_beat_t beat;
        noc_shim_pkg::axis_beat_t got;
        errors_before  = error_count;
        loopback       = 1'b1;
        beat.data.word = 64'h0123_4567_89ab_cdef;
        beat.dest      = 3'd5;
        beat.last      = 1'b1;
        send_beat(beat);
        recv_beat(1'b0, got);
        check_value("single_word", "data", beat.data.word, got.data.word);
        check_value("single_word", "dest", beat.dest, got.dest);
        check_value("single_word", "last", beat.last, got.last);
        wait_idle();
        finish_test("single_word", errors_before);
    endtask

    task automatic test_flit_framing();
        int                       errors_before;
        noc_shim_pkg::axis_beat_t beat;
        errors_before  = error_count;
        loopback       = 1'b0;
        beat.data.word = 64'hfeed_0bad_c0de_1234;
        beat.dest      = 3'd6;
        // Once with last set, once without
        for (int k = 0; k < 2; k++) begin
            beat.last = (k == 0);
            flits_seen.delete();
            fork
                send_beat(beat);
                watch_sends(30);
            join
            if (flits_seen.size() != 4) begin
                $display("ERROR flit_framing: saw %0d flits for one word instead of 4",
                         flits_seen.size());
                error_count++;
            end else begin
                for (int i = 0; i < 4; i++) begin
                    check_value("flit_framing", $sformatf("flit %0d data", i),
                                beat.data.word[16*i +: 16], flits_seen[i].data);
                    check_value("flit_framing", $sformatf("flit %0d dest", i),
                                beat.dest, flits_seen[i].dest);
                    check_value("flit_framing", $sformatf("flit %0d tail", i),
                                (i == 3) && beat.last, flits_seen[i].tail);
                end
            end
            drive_credits(4);
            wait_idle();
        end
        finish_test("flit_framing", errors_before);
    endtask

    task automatic test_credit_limit();
        int                       errors_before;
        noc_shim_pkg::axis_beat_t beat;
        errors_before  = error_count;
        loopback       = 1'b0;
        beat.data.word = 64'h1111_2222_3333_4444;
        beat.dest      = 3'd2;
        beat.last      = 1'b0;
        flits_seen.delete();
        fork
            begin
                send_beat(beat);
                send_beat(beat);
            end
            watch_sends(50);
        join
        check_value("credit_limit", "sends on starting credits", 4, flits_seen.size());
        flits_seen.delete();
        fork
            drive_credits(1);
            watch_sends(20);
        join
        check_value("credit_limit", "sends after one credit", 1, flits_seen.size());
        // Drain the second word and leave the sender with four credits
        drive_credits(7);
        wait_idle();
        finish_test("credit_limit", errors_before);
    endtask

    task automatic test_stream();
        int                       errors_before;
        logic [31:0]              hi;
        logic [31:0]              lo;
        logic [31:0]              ctl;
        noc_shim_pkg::axis_beat_t sent[$];
        noc_shim_pkg::axis_beat_t beat;
        noc_shim_pkg::axis_beat_t got;
        errors_before = error_count;
        for (int i = 0; i < 20; i++) begin
            hi             = next_random();
            lo             = next_random();
            ctl            = next_random();
            beat.data.word = {hi, lo};
            beat.dest      = ctl[2:0];
            beat.last      = ctl[3];
            sent.push_back(beat);
        end
        loopback = 1'b1;
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    send_beat(sent[i]);
                end
            end
            begin
                for (int i = 0; i < 20; i++) begin
                    recv_beat(1'b1, got);
                    check_value("stream", $sformatf("beat %0d", i), sent[i], got);
                end
            end
        join
        // All twenty taken, so nothing may be left to read
        check_value("stream", "rx_valid after last beat", 1'b0, rx_valid);
        wait_idle();
        finish_test("stream", errors_before);
    endtask

    initial begin
        rst_n_noc_sync = 1'b0;
        tx_valid       = 1'b0;
        tx_beat        = '0;
        rx_ready       = 1'b0;
        credit_drv     = 1'b0;
        loopback       = 1'b0;
        rng_state      = 32'hfb288fe4;
        cycle_count    = 0;
        error_count    = 0;
        test_count     = 0;

        test_reset_idle();
        test_single_word();
        test_flit_framing();
        test_credit_limit();
        test_stream();

        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tests/noc_shim_properties.sv */
`timescale 1ns/100ps

module noc_shim_properties (
    input logic                                     clk_noc,
    input logic                                     rst_n_noc_sync,
    input logic [noc_shim_pkg::credit_width-1:0]    credit_count,
    input logic                                     credit_in,
    input logic                                     send_out,
    input noc_shim_pkg::flit_t                      flit_out
);

    logic [noc_shim_pkg::credit_width-1:0]    in_flight;
    logic [noc_shim_pkg::ser_count_width-1:0] flit_pos;

    // Flits on the wire not yet paid back, and position of the next flit in its word
    always_ff @(posedge clk_noc) begin
        if (!rst_n_noc_sync) begin
            in_flight <= '0;
            flit_pos  <= '0;
        end else begin
            in_flight <= in_flight
                       + noc_shim_pkg::credit_width'(send_out)
                       - noc_shim_pkg::credit_width'(credit_in);
            if (send_out) begin
                flit_pos <= flit_pos + 1'b1;
            end
        end
    end

    // More flits outstanding than slots means a send without a credit
    property no_read_without_credit;
        @(posedge clk_noc) disable iff (!rst_n_noc_sync)
            in_flight <= noc_shim_pkg::credit_width'(noc_shim_pkg::flit_buffer_depth);
    endproperty

    property credits_bounded;
        @(posedge clk_noc) disable iff (!rst_n_noc_sync)
            credit_count <= noc_shim_pkg::credit_width'(noc_shim_pkg::flit_buffer_depth);
    endproperty

    property tail_on_last_flit;
        @(posedge clk_noc) disable iff (!rst_n_noc_sync)
            (send_out && flit_out.tail) |->
            (flit_pos == noc_shim_pkg::ser_count_width'(noc_shim_pkg::flits_per_word - 1));
    endproperty

    assert property (no_read_without_credit)
        else $error("flit read with no credit left");
    assert property (credits_bounded)
        else $error("credit counter above its starting value");
    assert property (tail_on_last_flit)
        else $error("tail flag on a flit other than the fourth");

endmodule

bind flit_serializer noc_shim_properties serializer_props (
    .clk_noc        (clk_noc),
    .rst_n_noc_sync (rst_n_noc_sync),
    .credit_count   (credit_count),
    .credit_in      (credit_in),
    .send_out       (send_out),
    .flit_out       (flit_out)
);

/* tests/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
    output logic clk
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

/* hdl/noc_endpoint_shim.sv */
`timescale 1ns/100ps

module noc_endpoint_shim (
    input  logic                     clk_noc,
    input  logic                     rst_n_noc_sync,
    input  logic                     tx_valid,
    output logic                     tx_ready,
    input  noc_shim_pkg::axis_beat_t tx_beat,
    output logic                     rx_valid,
    input  logic                     rx_ready,
    output noc_shim_pkg::axis_beat_t rx_beat,
    output noc_shim_pkg::flit_t      flit_out,
    output logic                     send_out,
    input  logic                     credit_in,
    input  noc_shim_pkg::flit_t      flit_in,
    input  logic                     send_in,
    output logic                     credit_out
);

    // Transmit path
    flit_serializer u_tx (
        .clk_noc        (clk_noc),
        .rst_n_noc_sync (rst_n_noc_sync),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_beat        (tx_beat),
        .flit_out       (flit_out),
        .send_out       (send_out),
        .credit_in      (credit_in)
    );

    // Receive path
    flit_deserializer u_rx (
        .clk_noc        (clk_noc),
        .rst_n_noc_sync (rst_n_noc_sync),
        .flit_in        (flit_in),
        .send_in        (send_in),
        .credit_out     (credit_out),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_beat        (rx_beat)
    );

endmodule

/* hdl/flit_deserializer.sv */
`timescale 1ns/100ps

module flit_deserializer (
    input  logic                     clk_noc,
    input  logic                     rst_n_noc_sync,
    input  noc_shim_pkg::flit_t      flit_in,
    input  logic                     send_in,
    output logic                     credit_out,
    output logic                     rx_valid,
    input  logic                     rx_ready,
    output noc_shim_pkg::axis_beat_t rx_beat
);

    noc_shim_pkg::axis_beat_t                 asm_beat;
    logic [noc_shim_pkg::ser_count_width-1:0] ser_count;
    logic                                     word_done;
    logic [noc_shim_pkg::credit_width-1:0]    pending_credits;
    logic                                     push;
    logic                                     buf_full;
    logic                                     buf_empty;
    logic                                     last_flit;

    assign last_flit =
        (ser_count == noc_shim_pkg::ser_count_width'(noc_shim_pkg::flits_per_word - 1));
    assign push       = word_done & ~buf_full;
    assign credit_out = (pending_credits != '0);
    assign rx_valid   = ~buf_empty;

    word_fifo #(
        .width ($bits(noc_shim_pkg::axis_beat_t)),
        .depth (noc_shim_pkg::word_buffer_depth)
    ) rx_buf (
        .clk_noc        (clk_noc),
        .rst_n_noc_sync (rst_n_noc_sync),
        .wr_en          (push),
        .wr_data        (asm_beat),
        .rd_en          (rx_valid & rx_ready),
        .rd_data        (rx_beat),
        .full           (buf_full),
        .empty          (buf_empty)
    );

    // Assembly register
    always_ff @(posedge clk_noc) begin
        if (send_in) begin
            asm_beat.data.flits[ser_count] <= flit_in.data;
            if (ser_count == '0) begin
                asm_beat.dest <= flit_in.dest;
            end
            if (last_flit) begin
                asm_beat.last <= flit_in.tail;
            end
        end
    end

    always_ff @(posedge clk_noc) begin
        if (!rst_n_noc_sync) begin
            ser_count       <= '0;
            word_done       <= 1'b0;
            pending_credits <= '0;
        end else begin
            if (send_in) begin
                ser_count <= ser_count + 1'b1;
            end
            // A full word holds its slots until it moves into the buffer
            if (send_in && last_flit) begin
                word_done <= 1'b1;
            end else if (push) begin
                word_done <= 1'b0;
            end
            pending_credits <= pending_credits
                + (push ? noc_shim_pkg::credit_width'(noc_shim_pkg::flits_per_word) : '0)
                - noc_shim_pkg::credit_width'(credit_out);
        end
    end

endmodule

/* hdl/flit_serializer.sv */
`timescale 1ns/100ps

module flit_serializer (
    input  logic                     clk_noc,
    input  logic                     rst_n_noc_sync,
    input  logic                     tx_valid,
    output logic                     tx_ready,
    input  noc_shim_pkg::axis_beat_t tx_beat,
    output noc_shim_pkg::flit_t      flit_out,
    output logic                     send_out,
    input  logic                     credit_in
);

    noc_shim_pkg::axis_beat_t                        head;
    logic                                            buf_full;
    logic                                            buf_empty;
    logic [noc_shim_pkg::credit_width-1:0]           credit_count;
    logic [noc_shim_pkg::ser_count_width-1:0]        ser_count;
    logic                                            rd_flit;
    logic                                            last_flit;

    assign tx_ready  = ~buf_full;
    assign rd_flit   = (credit_count != '0) & ~buf_empty;
    assign last_flit =
        (ser_count == noc_shim_pkg::ser_count_width'(noc_shim_pkg::flits_per_word - 1));

    word_fifo #(
        .width (   $bits(noc_shim_pkg::axis_beat_t)),
        .depth (noc_shim_pkg::word_buffer_depth)
    ) tx_buf (
        .clk_noc        (clk_noc),
        .rst_n_noc_sync (rst_n_noc_sync),
        .wr_en          (tx_valid & tx_ready),
        .wr_data        (tx_beat),
        .rd_en          (rd_flit & last_flit),
        .rd_data        (head),
        .full           (buf_full),
        .empty          (buf_empty)
    );

    // Credits come back one per pulse, one is spent per flit read
    always_ff @(posedge clk_noc) begin
        if (!rst_n_noc_sync) begin
            credit_count <= noc_shim_pkg::credit_width'(noc_shim_pkg::flit_buffer_depth);
            ser_count    <= '0;
            send_out     <= 1'b0;
        end else begin
            credit_count <= credit_count
                          + noc_shim_pkg::credit_width'(credit_in)
                          - noc_shim_pkg::credit_width'(rd_flit);
            if (rd_flit) begin
                ser_count <= ser_count + 1'b1;
            end
            send_out <= rd_flit;
        end
    end

    // Flit payload, lowest slice first
    always_ff @(posedge clk_noc) begin
        if (rd_flit) begin
            flit_out.data <= head.data.flits[ser_count];
            flit_out.dest <= head.dest;
            flit_out.tail <= head.last & last_flit;
        end
    end

endmodule

/* hdl/word_fifo.sv */
`timescale 1ns/100ps

module word_fifo #(
    parameter int width = 68,
    parameter int depth = 4
) (
    input  logic             clk_noc,
    input  logic             rst_n_noc_sync,
    input  logic             wr_en,
    input  logic [width-1:0] wr_data,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             full,
    output logic             empty
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    logic [width-1:0]       mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   do_wr;
    logic                   do_rd;

    assign full  = (count == count_width'(depth));
    assign empty = (count == '0);
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // Show-ahead: head entry is always on the output
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk_noc) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_noc) begin
        if (!rst_n_noc_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + count_width'(do_wr) - count_width'(do_rd);
        end
    end

endmodule

/* hdl/noc_shim_pkg.sv */
package noc_shim_pkg;

    // AXI-Stream side
    localparam int tdata_width = 64;
    localparam int tdest_width = 3;

    // NoC side
    localparam int flits_per_word = 4;
    localparam int flit_width = tdata_width / flits_per_word;

    // Receiver flit slots, also the sender's starting credits
    localparam int flit_buffer_depth = 4;
    localparam int word_buffer_depth = 4;

    localparam int credit_width = 3;
    localparam int ser_count_width = 2;

    // Element 0 of the flit view is the least significant slice
    typedef union packed {
        logic [tdata_width-1:0] word;
        logic [flits_per_word-1:0][flit_width-1:0] flits;
    } beat_u;

    typedef struct packed {
        beat_u data;
        logic [tdest_width-1:0] dest;
        logic last;
    } axis_beat_t;

    typedef struct packed {
        logic [flit_width-1:0] data;
        logic [tdest_width-1:0] dest;
        logic tail;
    } flit_t;

endpackage
